// File: spi_cfg.svh
/*
 * spi master build configuration
 * queue depth, receive word width and sclk divider field width
 */
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// transmit queue entries
// the host holds this many credits after reset
`define SPI_QUEUE_DEPTH 8

// receive word holding the last eight bytes of a frame
`define SPI_RX_BITS 64

// width of the sclk divider field
`define SPI_CLKDIV_W 8

`endif

// File: spi_mode_pkg.sv
/*
 * spi wire protocol types
 * frame engine states and the sclk divider value
 */
`default_nettype none
`include "spi_cfg.svh"

package spi_mode_pkg;

   // frame engine states in walking order
   // each state either stays or moves to the next one
   typedef enum logic [1:0] {
      SPI_IDLE  = 2'b00, // ss high and sclk parked
      SPI_SETUP = 2'b01, // ss low before the first edge
      SPI_DATA  = 2'b10, // sclk running
      SPI_HOLD  = 2'b11  // ss kept low after the last edge
   } spi_state_t;

   // half period is value+1 clk cycles
   typedef logic [`SPI_CLKDIV_W-1:0] spi_div_t;

endpackage

`default_nettype wire

// File: spi_flow_pkg.sv
/*
 * host side data types
 * payload bytes, receive word and credit count
 */
`default_nettype none
`include "spi_cfg.svh"

package spi_flow_pkg;

   // one queued byte
   typedef logic [7:0] spi_byte_t;

   // received bits of the frame
   typedef logic [`SPI_RX_BITS-1:0] spi_rx_word_t;

   // 0..depth inclusive
   typedef logic [$clog2(`SPI_QUEUE_DEPTH+1)-1:0] spi_credit_t;

endpackage

`default_nettype wire

// File: spi_clock_div.sv
/*
 * sclk divider
 * half period of div+1 clk cycles with one-cycle strobes ahead of each sclk edge
 */
`timescale 1ns/10ps
`default_nettype none

module spi_clock_div (
   input  wire                         clk,        // core clock
   input  wire                         nreset,     // async active low reset
   input  wire spi_mode_pkg::spi_div_t div,        // half period minus one
   input  wire                         run,        // divider enable
   output logic                        edge_lead,  // sclk leaves rest next cycle
   output logic                        edge_trail, // sclk returns to rest next cycle
   output logic                        sclk_int    // sclk before polarity
);

   import spi_mode_pkg::*;

   spi_div_t cnt;    // cycles spent in this phase
   logic     toggle; // last cycle of a half period

   //####################
   // strobes
   //####################

   // >= keeps the counter sane if div is lowered mid count
   assign toggle     = run & (cnt >= div);
   assign edge_lead  = toggle & ~sclk_int; // rest -> active
   assign edge_trail = toggle & sclk_int;  // active -> rest

   //####################
   // phase counter
   //####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt      <= '0;
         sclk_int <= 1'b0;
      end else if (!run) begin
         cnt      <= '0;   // park at rest level
         sclk_int <= 1'b0;
      end else if (toggle) begin
         cnt      <= '0;
         sclk_int <= ~sclk_int;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: spi_tx_queue.sv
/*
 * transmit byte queue
 * circular buffer that hands back one credit for every byte popped
 */
`timescale 1ns/10ps
`default_nettype none
`include "spi_cfg.svh"

module spi_tx_queue (
   input  wire                          clk,      // core clock
   input  wire                          nreset,   // async active low reset
   input  wire                          wr_valid, // host write
   input  wire spi_flow_pkg::spi_byte_t wr_data,  // host byte
   input  wire                          pop,      // engine takes the head
   output spi_flow_pkg::spi_byte_t      rd_data,  // head byte
   output logic                         empty,    // nothing queued
   output logic                         credit    // byte popped last cycle
);

   import spi_flow_pkg::*;

   localparam int DEPTH = `SPI_QUEUE_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   spi_byte_t     mem [DEPTH]; // storage
   logic [AW-1:0] wr_ptr;      // next free slot
   logic [AW-1:0] rd_ptr;      // head slot
   spi_credit_t   fill;        // bytes held
   logic          full;
   logic          wr_en;
   logic          rd_en;

   assign full    = (fill == spi_credit_t'(DEPTH));
   assign empty   = (fill == '0);
   assign wr_en   = wr_valid & ~full;
   assign rd_en   = pop & ~empty;
   assign rd_data = mem[rd_ptr]; // valid in the pop cycle

   //####################
   // storage
   //####################

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   //####################
   // pointers and credit
   //####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         credit <= 1'b0;
      end else begin
         if (wr_en)
            wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1; // wrap
         if (rd_en)
            rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         fill   <= fill + spi_credit_t'(wr_en) - spi_credit_t'(rd_en);
         credit <= rd_en; // one credit back per byte
      end
   end

   //####################
   // protocol checks
   //####################

   // host writes only while it holds a credit so a full queue never sees one
   a_no_overflow : assert property (@(posedge clk) disable iff (!nreset)
      wr_valid |-> !full);

   // frame engine pops only after seeing the queue non-empty
   a_no_underflow : assert property (@(posedge clk) disable iff (!nreset)
      pop |-> !empty);

endmodule

`default_nettype wire

// File: spi_par2ser.sv
/*
 * transmit serializer
 * loadable byte shift register with a registered mosi bit and a busy flag
 */
`timescale 1ns/10ps
`default_nettype none

module spi_par2ser (
   input  wire                          clk,      // core clock
   input  wire                          nreset,   // async active low reset
   input  wire                          load,     // capture din
   input  wire spi_flow_pkg::spi_byte_t din,      // byte from the queue
   input  wire                          shift,    // next bit out
   input  wire                          lsbfirst, // bit order
   output logic                         dout,     // mosi
   output logic                         busy      // bits left to send
);

   import spi_flow_pkg::*;

   spi_byte_t  sreg;   // bits not yet sent
   spi_byte_t  src;    // byte the next bit comes from
   logic [3:0] remain; // 0..8
   logic       head;   // bit that goes out on shift

   // load and shift may land in the same cycle at the fastest divider
   assign src  = load ? din : sreg;
   assign head = lsbfirst ? src[0] : src[7];
   assign busy = (remain != '0);

   // payload
   always_ff @(posedge clk) begin
      if (shift)
         sreg <= lsbfirst ? {1'b0, src[7:1]} : {src[6:0], 1'b0};
      else if (load)
         sreg <= din;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         remain <= '0;
         dout   <= 1'b0;
      end else begin
         if (shift)
            dout <= head;               // mosi changes with the shift strobe
         if (load & shift)
            remain <= 4'd7;             // first bit already gone
         else if (load)
            remain <= 4'd8;
         else if (shift & busy)
            remain <= remain - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: spi_ser2par.sv
/*
 * receive deserializer
 * shifts miso into the receive word in the selected bit order
 */
`timescale 1ns/10ps
`default_nettype none
`include "spi_cfg.svh"

module spi_ser2par (
   input  wire                         clk,      // core clock
   input  wire                         nreset,   // async active low reset
   input  wire                         sample,   // take one miso bit
   input  wire                         din,      // miso
   input  wire                         lsbfirst, // bit order
   output spi_flow_pkg::spi_rx_word_t  dout      // last received bits
);

   // word holds its value between frames
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         dout <= '0;
      end else if (sample) begin
         if (lsbfirst)
            dout <= {din, dout[`SPI_RX_BITS-1:1]}; // enter at the top
         else
            dout <= {dout[`SPI_RX_BITS-2:0], din}; // newest byte lowest
      end
   end

endmodule

`default_nettype wire

// File: spi_master_io.sv
/*
 * spi master frame engine
 * drives ss and sclk and picks shift and sample edges from cpha
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master_io (
   input  wire                            clk,      // core clock
   input  wire                            nreset,   // async active low reset
   input  wire                            cpol,     // sclk rest level
   input  wire                            cpha,     // sample on trailing edge
   input  wire                            lsbfirst, // bit order
   input  wire spi_mode_pkg::spi_div_t    div,      // sclk divider
   input  wire spi_flow_pkg::spi_byte_t   q_data,   // queue head
   input  wire                            q_empty,  // queue empty
   output logic                           q_pop,    // take queue head
   output spi_mode_pkg::spi_state_t       state,    // frame engine state
   output spi_flow_pkg::spi_rx_word_t     rx_data,  // received word
   output logic                           rx_done,  // frame finished
   output logic                           sclk,     // spi clock pin
   output logic                           mosi,     // master out
   output logic                           ss,       // slave select
   input  wire                            miso      // master in
);

   import spi_mode_pkg::*;

   logic      edge_lead;  // strobe ahead of leading edge
   logic      edge_trail; // strobe ahead of trailing edge
   logic      sclk_int;   // raw divider output
   logic      in_idle;
   logic      in_setup;
   logic      in_data;
   logic      shift;      // mosi advances
   logic      sample;     // miso captured
   logic      busy;       // serializer has bits left
   logic      load_byte;  // popped byte goes into serializer
   logic      data_done;  // leave data state
   logic      ss_q;       // ss one cycle ago
   logic [7:0] pop_data;  // byte taken in the pop cycle

   assign in_idle  = (state == SPI_IDLE);
   assign in_setup = (state == SPI_SETUP);
   assign in_data  = (state == SPI_DATA);

   //####################
   // clock
   //####################

   spi_clock_div u_clock_div (
      .clk        (clk),
      .nreset     (nreset),
      .div        (div),
      .run        (~in_idle),   // parked while idle
      .edge_lead  (edge_lead),
      .edge_trail (edge_trail),
      .sclk_int   (sclk_int)
   );

   assign sclk = (sclk_int & in_data) ^ cpol; // only toggles in data

   // cpha 0 pushes the first bit out on the setup trailing strobe
   assign shift  = cpha ? (edge_lead & in_data) : (edge_trail & (in_setup | in_data));
   assign sample = cpha ? (edge_trail & in_data) : (edge_lead & in_data);

   //####################
   // frame engine
   //####################

   // next byte leaves the queue on the sample after its predecessor's last shift
   assign q_pop     = ~q_empty & (in_idle | (sample & ~busy));
   assign data_done = edge_trail & ~busy & ~load_byte & ~q_pop;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state <= SPI_IDLE;
      end else begin
         case (state)
            SPI_IDLE  : if (q_pop)      state <= SPI_SETUP;
            SPI_SETUP : if (edge_trail) state <= SPI_DATA;
            SPI_DATA  : if (data_done)  state <= SPI_HOLD;
            SPI_HOLD  : if (edge_trail) state <= SPI_IDLE;
            default   :                 state <= SPI_IDLE;
         endcase
      end
   end

   assign ss = in_idle; // active low

   always_ff @(posedge clk) begin
      if (q_pop)
         pop_data <= q_data; // head moves on after the pop
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         load_byte <= 1'b0;
         ss_q      <= 1'b1;
         rx_done   <= 1'b0;
      end else begin
         load_byte <= q_pop;      // one cycle pop to load
         ss_q      <= ss;
         rx_done   <= ss & ~ss_q; // cycle after ss rises
      end
   end

   //####################
   // shift registers
   //####################

   spi_par2ser u_par2ser (
      .clk      (clk),
      .nreset   (nreset),
      .load     (load_byte),
      .din      (pop_data),
      .shift    (shift),
      .lsbfirst (lsbfirst),
      .dout     (mosi),
      .busy     (busy)
   );

   spi_ser2par u_ser2par (
      .clk      (clk),
      .nreset   (nreset),
      .sample   (sample),
      .din      (miso),
      .lsbfirst (lsbfirst),
      .dout     (rx_data)
   );

   // states advance one step at a time in idle setup data hold order
   a_state_order : assert property (@(posedge clk) disable iff (!nreset)
      (state == $past(state)) || (state == spi_state_t'($past(state) + 2'd1)));

endmodule

`default_nettype wire

// File: spi_master.sv
/*
 * byte stream spi master
 * credit flow transmit queue feeding the frame engine
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master (
   input  wire                          clk,       // core clock
   input  wire                          nreset,    // async active low reset
   input  wire                          cpol,      // sclk rest level
   input  wire                          cpha,      // clock phase
   input  wire                          lsbfirst,  // bit order
   input  wire spi_mode_pkg::spi_div_t  div,       // sclk divider
   input  wire                          tx_valid,  // host byte write
   input  wire spi_flow_pkg::spi_byte_t tx_data,   // host byte
   output logic                         tx_credit, // one credit returned
   output spi_mode_pkg::spi_state_t     state,     // frame engine state
   output spi_flow_pkg::spi_rx_word_t   rx_data,   // received word
   output logic                         rx_done,   // frame finished
   output logic                         sclk,      // spi clock
   output logic                         mosi,      // master out
   output logic                         ss,        // slave select
   input  wire                          miso       // master in
);

   import spi_flow_pkg::*;

   spi_byte_t q_data;  // queue head
   logic      q_empty;
   logic      q_pop;

   spi_tx_queue u_tx_queue (
      .clk      (clk),
      .nreset   (nreset),
      .wr_valid (tx_valid),
      .wr_data  (tx_data),
      .pop      (q_pop),
      .rd_data  (q_data),
      .empty    (q_empty),
      .credit   (tx_credit)
   );

   spi_master_io u_master_io (
      .clk      (clk),
      .nreset   (nreset),
      .cpol     (cpol),
      .cpha     (cpha),
      .lsbfirst (lsbfirst),
      .div      (div),
      .q_data   (q_data),
      .q_empty  (q_empty),
      .q_pop    (q_pop),
      .state    (state),
      .rx_data  (rx_data),
      .rx_done  (rx_done),
      .sclk     (sclk),
      .mosi     (mosi),
      .ss       (ss),
      .miso     (miso)
   );

endmodule

`default_nettype wire

// File: tb_spi_slave_model.sv
/*
 * behavioral spi slave
 * logs mosi bits and shifts out reply bytes per cpol, cpha and bit order
 */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_slave_model (
   input  wire        cpol,       // sclk rest level
   input  wire        cpha,       // clock phase
   input  wire        lsbfirst,   // bit order
   input  wire        sclk,
   input  wire        mosi,
   input  wire        ss,         // active low
   input  wire [63:0] reply,      // byte i at [8i +: 8]
   output logic       miso,
   output logic [63:0] mosi_log,  // bit k is the k-th mosi bit of the frame
   output int         lead_edges, // sclk edges leaving rest
   output int         frames      // ss falling edges seen
);

   logic        ss_q   = 1'b1;
   logic        sclk_q = 1'b0;
   logic        miso_r = 1'b0;
   logic [63:0] log_r  = '0;
   int          n_lead = 0;
   int          n_frm  = 0;
   int          tx_idx = 0; // next reply bit
   int          rx_idx = 0; // next mosi bit
   logic        lead;

   assign miso       = miso_r;
   assign mosi_log   = log_r;
   assign lead_edges = n_lead;
   assign frames     = n_frm;

   // k-th reply bit on the wire
   function automatic logic reply_bit(int k);
      if (k >= 64)
         return 1'b0;
      return lsbfirst ? reply[8*(k/8) + k%8] : reply[8*(k/8) + 7 - k%8];
   endfunction

   always @(ss or sclk) begin
      if (!ss && ss_q) begin
         n_frm++;                // frame start
         n_lead = 0;
         log_r  = '0;
         rx_idx = 0;
         tx_idx = 0;
         if (!cpha) begin
            miso_r = reply_bit(0); // first bit before any edge
            tx_idx = 1;
         end
      end else if (!ss && sclk !== sclk_q) begin
         lead = (sclk != cpol);
         if (lead)
            n_lead++;
         if (lead ^ cpha) begin
            if (rx_idx < 64)
               log_r[rx_idx] = mosi; // sample edge
            rx_idx++;
         end else begin
            miso_r = reply_bit(tx_idx);
            tx_idx++;
         end
      end
      ss_q   = ss;
      sclk_q = sclk;
   end

endmodule

`default_nettype wire

// File: tb_spi_master.sv
/*
 * spi master testbench
 * table of frames over all modes with credit tracking and slave model checks
 */
`timescale 1ns/10ps
`default_nettype none
`include "spi_cfg.svh"

module tb_spi_master;

   import spi_mode_pkg::*;
   import spi_flow_pkg::*;

   typedef struct packed {
      logic       cpol;
      logic       cpha;
      logic       lsbfirst;
      spi_div_t   div;
      logic [3:0] nbytes; // 1..8
      logic [7:0] salt;   // mixed into the lfsr
   } row_t;

   //####################
   // stimulus table
   //####################

   localparam int NUM_ROWS = 12;
   localparam row_t ROWS [NUM_ROWS] = '{
      {1'b0, 1'b0, 1'b0, 8'd0, 4'd1, 8'h3c},
      {1'b0, 1'b0, 1'b0, 8'd3, 4'd8, 8'h5a},
      {1'b0, 1'b1, 1'b0, 8'd1, 4'd4, 8'h91},
      {1'b1, 1'b0, 1'b0, 8'd2, 4'd3, 8'h07},
      {1'b1, 1'b1, 1'b0, 8'd0, 4'd8, 8'hc3},
      {1'b0, 1'b0, 1'b1, 8'd4, 4'd5, 8'h2e},
      {1'b0, 1'b1, 1'b1, 8'd0, 4'd2, 8'h64},
      {1'b1, 1'b0, 1'b1, 8'd1, 4'd8, 8'hb8},
      {1'b1, 1'b1, 1'b1, 8'd5, 4'd6, 8'h19},
      {1'b0, 1'b0, 1'b0, 8'd7, 4'd7, 8'hf0},
      {1'b1, 1'b1, 1'b0, 8'd2, 4'd1, 8'h4d},
      {1'b0, 1'b1, 1'b1, 8'd3, 4'd8, 8'ha2}
   };

   logic         clk;
   logic         nreset;
   logic         cpol;
   logic         cpha;
   logic         lsbfirst;
   spi_div_t     div;
   logic         tx_valid;
   spi_byte_t    tx_data;
   logic         tx_credit;
   spi_state_t   state;
   spi_rx_word_t rx_data;
   logic         rx_done;
   logic         sclk;
   logic         mosi;
   logic         ss;
   logic         miso;
   logic [63:0]  reply;      // slave reply bytes
   logic [63:0]  mosi_log;
   int           lead_edges;
   int           frames;

   int           value_errors;
   int           other_errors;
   spi_credit_t  credits;       // host side credit counter
   int           credit_pulses;
   logic [31:0]  lfsr;
   int           hp_cnt;        // cycles since last sclk change
   logic         hp_seen;
   logic         sclk_last;

   spi_master UUT (
      .clk(clk), .nreset(nreset), .cpol(cpol), .cpha(cpha), .lsbfirst(lsbfirst),
      .div(div), .tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
      .state(state), .rx_data(rx_data), .rx_done(rx_done), .sclk(sclk),
      .mosi(mosi), .ss(ss), .miso(miso)
   );

   tb_spi_slave_model u_slave (
      .cpol(cpol), .cpha(cpha), .lsbfirst(lsbfirst), .sclk(sclk), .mosi(mosi),
      .ss(ss), .reply(reply), .miso(miso), .mosi_log(mosi_log),
      .lead_edges(lead_edges), .frames(frames)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   //####################
   // helpers
   //####################

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic spi_byte_t lfsr_byte();
      spi_byte_t b;
      b = '0;
      for (int i = 0; i < 8; i++)
         b = {b[6:0], lfsr_bit()};
      return b;
   endfunction

   function automatic int watchdog_cycles();
      int sum;
      sum = 20; // reset and settling
      for (int r = 0; r < NUM_ROWS; r++)
         sum += ROWS[r].nbytes * 16 * (ROWS[r].div + 1) + 200;
      return sum;
   endfunction

   task automatic compare_byte(string name, spi_byte_t got, spi_byte_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_word(string name, spi_rx_word_t got, spi_rx_word_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_credit(string name, spi_credit_t got, spi_credit_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_state(string name, spi_state_t got, spi_state_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic compare_count(string name, int got, int exp);
      if (got !== exp) begin
         value_errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   //####################
   // monitors
   //####################

   // posedge sees last cycle's settled values
   always @(posedge clk) begin
      if (nreset) begin
         if (tx_credit) begin
            if (credits == spi_credit_t'(`SPI_QUEUE_DEPTH)) begin
               other_errors++;
               $display("credit returned while none was outstanding");
            end
            credits++;
            credit_pulses++;
         end
         if (state != SPI_DATA && sclk !== cpol) begin
            other_errors++;
            $display("sclk left its rest level outside the data state");
         end
         if (ss) begin
            hp_seen   = 1'b0;
            hp_cnt    = 0;
            sclk_last = cpol;
         end else if (sclk !== sclk_last) begin
            if (hp_seen)
               compare_count("sclk half period", hp_cnt, div + 1);
            hp_seen   = 1'b1;
            hp_cnt    = 1;
            sclk_last = sclk;
         end else begin
            hp_cnt++;
         end
      end
   end

   // watchdog
   initial begin
      int limit;
      limit = watchdog_cycles();
      repeat (limit) @(posedge clk);
      $display("timeout, frames did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
   end

   //####################
   // main sequence
   //####################

   initial begin
      row_t         row;
      spi_byte_t    tx_bytes [8];
      spi_byte_t    rx_bytes [8];
      spi_byte_t    got;
      spi_rx_word_t exp_rx;
      int           pulses_start;
      int           frames_start;

      nreset        = 1'b0;
      cpol          = 1'b0;
      cpha          = 1'b0;
      lsbfirst      = 1'b0;
      div           = '0;
      tx_valid      = 1'b0;
      tx_data       = '0;
      reply         = '0;
      value_errors  = 0;
      other_errors  = 0;
      credit_pulses = 0;
      credits = spi_credit_t'(`SPI_QUEUE_DEPTH);
      lfsr = 32'h40e84299;
      hp_cnt    = 0;
      hp_seen   = 1'b0;
      sclk_last = 1'b0;
      exp_rx = '0; // receive word resets to zero

      repeat (3) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      repeat (4) @(negedge clk);

      // idle after reset
      compare_count("ss", ss, 1);
      compare_count("sclk", sclk, cpol);
      compare_count("rx_done", rx_done, 0);
      compare_state("state", state, SPI_IDLE);
      compare_count("credit pulses before write", credit_pulses, 0);

      for (int r = 0; r < NUM_ROWS; r++) begin
         row = ROWS[r];
         compare_word("rx_data held", rx_data, exp_rx);
         cpol     = row.cpol;
         cpha     = row.cpha;
         lsbfirst = row.lsbfirst;
         div      = row.div;
         lfsr     = lfsr ^ {24'h0, row.salt};
         if (lfsr == '0)
            lfsr = 32'h40e84299;
         for (int i = 0; i < row.nbytes; i++) begin
            tx_bytes[i] = lfsr_byte();
            rx_bytes[i] = lfsr_byte();
            reply[8*i +: 8] = rx_bytes[i];
         end
         pulses_start = credit_pulses;
         frames_start = frames;
         @(negedge clk);

         // bytes back to back with one credit each
         for (int i = 0; i < row.nbytes; i++) begin
            if (credits == '0) begin
               other_errors++;
               $display("host ran out of credits in row %0d", r);
            end
            tx_valid = 1'b1;
            tx_data  = tx_bytes[i];
            credits--;
            @(negedge clk);
         end
         tx_valid = 1'b0;

         while (!rx_done)
            @(negedge clk);

         compare_count("ss at rx_done", ss, 1);
         compare_state("state at rx_done", state, SPI_IDLE);

         // newest byte lowest for msb first and highest for lsb first
         for (int i = 0; i < row.nbytes; i++) begin
            if (row.lsbfirst)
               exp_rx = {rx_bytes[i], exp_rx[63:8]};
            else
               exp_rx = {exp_rx[55:0], rx_bytes[i]};
         end
         compare_word("rx_data", rx_data, exp_rx);

         for (int i = 0; i < row.nbytes; i++) begin
            got = '0;
            for (int k = 0; k < 8; k++)
               got[row.lsbfirst ? k : 7 - k] = mosi_log[8*i + k];
            compare_byte($sformatf("mosi byte %0d row %0d", i, r), got, tx_bytes[i]);
         end
         compare_count("sclk leading edges", lead_edges, 8 * row.nbytes);
         compare_count("ss falls per frame", frames - frames_start, 1);
         compare_count("credit pulses", credit_pulses - pulses_start, row.nbytes);
         compare_credit("credits", credits, spi_credit_t'(`SPI_QUEUE_DEPTH));
         @(negedge clk);
      end

      $display("run complete, value errors %0d, other errors %0d",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
spi_mode_pkg.sv
spi_flow_pkg.sv
spi_clock_div.sv
spi_tx_queue.sv
spi_par2ser.sv
spi_ser2par.sv
spi_master_io.sv
spi_master.sv
tb_spi_slave_model.sv
tb_spi_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spi master testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module tb_spi_master -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

echo "simulation finished without failure"
exit 0
